//--- hw/srio_pkg.sv
package srio_pkg;

    // Frame types used on the request and response streams
    typedef enum logic [3:0] {
        FTYPE_NWRITE   = 4'h5,
        FTYPE_DOORBELL = 4'hA
    } ftype_e;

    localparam logic [3:0] TTYPE_NWRITE = 4'h4;
    localparam logic [1:0] REQ_PRIO     = 2'h1;

    // Doorbell info codes
    localparam logic [15:0] DB_INFO_SELF_CHECK = 16'h0101;
    localparam logic [15:0] DB_INFO_READY      = 16'h0100;
    localparam logic [15:0] DB_INFO_BUSY       = 16'h01FF;
    // Inverted parity is added on top of this one
    localparam logic [15:0] DB_INFO_INTEG_BASE = 16'h0200;

    localparam int ADDR_W = 34;
    // Second target window sits 1 MB above the first
    localparam logic [ADDR_W-1:0] TARGET_ADDR_STRIDE = ADDR_W'(1 << 20);

    typedef logic [63:0] beat_data_t;
    typedef logic [7:0]  beat_keep_t;
    // Upper half source ID, lower half destination ID
    typedef logic [31:0] beat_user_t;

    // Header field positions
    localparam int TID_HI   = 63;
    localparam int TID_LO   = 56;
    localparam int FTYPE_HI = 55;
    localparam int FTYPE_LO = 52;
    localparam int TTYPE_HI = 51;
    localparam int TTYPE_LO = 48;
    localparam int PRIO_HI  = 46;
    localparam int PRIO_LO  = 45;
    localparam int SIZE_HI  = 43;
    localparam int SIZE_LO  = 36;
    localparam int ADDR_HI  = 33;
    localparam int ADDR_LO  = 0;
    localparam int INFO_HI  = 31;
    localparam int INFO_LO  = 16;

endpackage

//--- hw/db_ctrl_pkg.sv
package db_ctrl_pkg;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DB_REQ,
        ST_DB_RESP,
        ST_NWR,
        ST_INTEG_REQ,
        ST_INTEG_WAIT
    } seq_state_e;

    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_DOORBELL,
        CMD_NWRITE
    } req_cmd_e;

    typedef enum logic [1:0] {
        ERR_NONE          = 2'd0,
        ERR_DB_TIMEOUT    = 2'd1,
        ERR_INTEG_TIMEOUT = 2'd2
    } err_type_e;

    localparam int RESP_TIMEOUT_CYCLES = 4096;
    localparam int TIMER_W             = $clog2(RESP_TIMEOUT_CYCLES);
    localparam int PAYLOAD_FIFO_DEPTH  = 64;
    localparam int FIFO_PTR_W          = $clog2(PAYLOAD_FIFO_DEPTH);

endpackage

//--- hw/srio_beat_if.sv
`timescale 1ns/1ps

interface srio_beat_if;
    import srio_pkg::*;

    logic       valid;
    logic       ready;
    beat_data_t data;
    beat_keep_t keep;
    logic       last;
    beat_user_t user;

    // Source holds all fields while valid is high and ready is low
    modport source (
        output valid, data, keep, last, user,
        input  ready
    );

    modport sink (
        input  valid, data, keep, last, user,
        output ready
    );

endinterface

//--- hw/user_payload_fifo.sv
`timescale 1ns/1ps

module user_payload_fifo (
    input  logic                 log_clk,
    input  logic                 log_rst,
    input  logic                 user_tvalid_i,
    output logic                 user_tready_o,
    input  srio_pkg::beat_data_t user_tdata_i,
    input  srio_pkg::beat_keep_t user_tkeep_i,
    input  logic                 user_tlast_i,
    input  logic [7:0]           user_tsize_i,
    srio_beat_if.source          head
);
    import srio_pkg::*;
    import db_ctrl_pkg::*;

    beat_data_t data_mem [PAYLOAD_FIFO_DEPTH];
    beat_keep_t keep_mem [PAYLOAD_FIFO_DEPTH];
    logic       last_mem [PAYLOAD_FIFO_DEPTH];
    logic [7:0] size_mem [PAYLOAD_FIFO_DEPTH];

    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  in_first;
    logic [7:0]            size_q;
    logic                  push;
    logic                  pop;

    // Depth is a power of two, so the MSB of count means full
    assign user_tready_o = ~count[FIFO_PTR_W];
    assign push = user_tvalid_i & user_tready_o;
    assign pop  = head.valid & head.ready;

    always_ff @(posedge log_clk) begin
        if (push) begin
            data_mem[wr_ptr] <= user_tdata_i;
            keep_mem[wr_ptr] <= user_tkeep_i;
            last_mem[wr_ptr] <= user_tlast_i;
            // Later beats repeat the size seen on the first one
            size_mem[wr_ptr] <= in_first ? user_tsize_i : size_q;
        end
        if (push && in_first) begin
            size_q <= user_tsize_i;
        end
    end

    always_ff @(posedge log_clk) begin
        if (log_rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_first <= 1'b1;
        end else begin
            if (push) begin
                wr_ptr   <= wr_ptr + 1'b1;
                in_first <= user_tlast_i;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{FIFO_PTR_W{1'b0}}, push} - {{FIFO_PTR_W{1'b0}}, pop};
        end
    end

    assign head.valid = (count != '0);
    assign head.data  = data_mem[rd_ptr];
    assign head.keep  = keep_mem[rd_ptr];
    assign head.last  = last_mem[rd_ptr];
    assign head.user  = {24'h0, size_mem[rd_ptr]};

endmodule

//--- hw/ireq_composer.sv
`timescale 1ns/1ps

module ireq_composer (
    input  logic                  log_clk,
    input  logic                  log_rst,
    input  db_ctrl_pkg::req_cmd_e req_cmd_i,
    input  logic [15:0]           db_info_i,
    input  logic                  parity_i,
    input  logic [15:0]           src_id_i,
    input  logic [15:0]           des_id_i,
    srio_beat_if.sink             payload,
    output logic                  ireq_tvalid_o,
    input  logic                  ireq_tready_i,
    output logic                  ireq_tlast_o,
    output srio_pkg::beat_data_t  ireq_tdata_o,
    output srio_pkg::beat_keep_t  ireq_tkeep_o,
    output srio_pkg::beat_user_t  ireq_tuser_o,
    output logic                  req_done_o
);
    import srio_pkg::*;
    import db_ctrl_pkg::*;

    logic       first_q;
    logic       xfer;
    beat_data_t db_beat;
    beat_data_t nwr_hdr;

    always_comb begin
        db_beat = '0;
        db_beat[FTYPE_HI:FTYPE_LO] = FTYPE_DOORBELL;
        db_beat[PRIO_HI:PRIO_LO]   = REQ_PRIO;
        db_beat[INFO_HI:INFO_LO]   = db_info_i;
    end

    // Header takes its size from the first payload beat at the FIFO head
    always_comb begin
        nwr_hdr = '0;
        nwr_hdr[TID_HI:TID_LO]     = {7'h0, parity_i};
        nwr_hdr[FTYPE_HI:FTYPE_LO] = FTYPE_NWRITE;
        nwr_hdr[TTYPE_HI:TTYPE_LO] = TTYPE_NWRITE;
        nwr_hdr[PRIO_HI:PRIO_LO]   = REQ_PRIO;
        nwr_hdr[SIZE_HI:SIZE_LO]   = payload.user[7:0];
        nwr_hdr[ADDR_HI:ADDR_LO]   = parity_i ? TARGET_ADDR_STRIDE : '0;
    end

    always_comb begin
        ireq_tvalid_o = 1'b0;
        ireq_tlast_o  = 1'b0;
        ireq_tdata_o  = '0;
        ireq_tkeep_o  = '1;
        payload.ready = 1'b0;
        case (req_cmd_i)
            CMD_DOORBELL: begin
                ireq_tvalid_o = 1'b1;
                ireq_tlast_o  = 1'b1;
                ireq_tdata_o  = db_beat;
            end
            CMD_NWRITE: begin
                ireq_tvalid_o = payload.valid;
                if (first_q) begin
                    ireq_tdata_o = nwr_hdr;
                end else begin
                    ireq_tdata_o  = payload.data;
                    ireq_tkeep_o  = payload.keep;
                    ireq_tlast_o  = payload.last;
                    // Payload leaves the FIFO only on the request handshake
                    payload.ready = ireq_tready_i;
                end
            end
            default: begin
            end
        endcase
    end

    assign ireq_tuser_o = {src_id_i, des_id_i};
    assign xfer         = ireq_tvalid_o & ireq_tready_i;
    assign req_done_o   = xfer & ireq_tlast_o;

    // High while the next NWRITE beat is the header
    always_ff @(posedge log_clk) begin
        if (log_rst) begin
            first_q <= 1'b1;
        end else if (req_cmd_i != CMD_NWRITE) begin
            first_q <= 1'b1;
        end else if (xfer) begin
            first_q <= ireq_tlast_o;
        end
    end

endmodule

//--- hw/iresp_decoder.sv
`timescale 1ns/1ps

module iresp_decoder (
    input  logic                 log_clk,
    input  logic                 log_rst,
    input  logic [15:0]          des_id_i,
    input  logic [15:0]          expect_info_i,
    input  logic                 iresp_tvalid_i,
    input  srio_pkg::beat_data_t iresp_tdata_i,
    input  srio_pkg::beat_user_t iresp_tuser_i,
    output logic                 resp_ready_o,
    output logic                 resp_busy_o,
    output logic                 resp_confirm_o
);
    import srio_pkg::*;

    logic        db_hit;
    logic [15:0] info;

    // Only doorbells from the addressed target count
    assign db_hit = iresp_tvalid_i
                  && (iresp_tdata_i[FTYPE_HI:FTYPE_LO] == FTYPE_DOORBELL)
                  && (iresp_tuser_i[31:16] == des_id_i);
    assign info = iresp_tdata_i[INFO_HI:INFO_LO];

    always_ff @(posedge log_clk) begin
        if (log_rst) begin
            resp_ready_o   <= 1'b0;
            resp_busy_o    <= 1'b0;
            resp_confirm_o <= 1'b0;
        end else begin
            resp_ready_o   <= db_hit && (info == DB_INFO_READY);
            resp_busy_o    <= db_hit && (info == DB_INFO_BUSY);
            resp_confirm_o <= db_hit && (info == expect_info_i);
        end
    end

endmodule

//--- hw/db_sequencer.sv
`timescale 1ns/1ps

module db_sequencer (
    input  logic                   log_clk,
    input  logic                   log_rst,
    input  logic                   link_initialized_i,
    input  logic                   self_check_i,
    input  logic                   nwr_req_i,
    input  logic                   req_done_i,
    input  logic                   resp_ready_i,
    input  logic                   resp_busy_i,
    input  logic                   resp_confirm_i,
    output db_ctrl_pkg::req_cmd_e  req_cmd_o,
    output logic [15:0]            db_info_o,
    output logic                   parity_o,
    output logic                   rapidio_ready_o,
    output logic                   nwr_ready_o,
    output logic                   nwr_busy_o,
    output logic                   nwr_ack_done_o,
    output logic                   error_o,
    output db_ctrl_pkg::err_type_e error_type_o
);
    import srio_pkg::*;
    import db_ctrl_pkg::*;

    seq_state_e         state_q;
    seq_state_e         state_d;
    logic [TIMER_W-1:0] timer_q;
    logic               waiting;
    logic               timeout;
    logic               self_start;
    logic               nwr_start;

    assign waiting = (state_q == ST_DB_RESP) || (state_q == ST_INTEG_WAIT);
    assign timeout = waiting && (timer_q == TIMER_W'(RESP_TIMEOUT_CYCLES - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                // Self-check wins over a pending NWRITE
                if (link_initialized_i && self_check_i) begin
                    state_d = ST_DB_REQ;
                end else if (link_initialized_i && nwr_req_i) begin
                    state_d = ST_NWR;
                end
            end
            ST_DB_REQ:     if (req_done_i) state_d = ST_DB_RESP;
            ST_DB_RESP:    if (resp_ready_i || resp_busy_i || timeout) state_d = ST_IDLE;
            ST_NWR:        if (req_done_i) state_d = ST_INTEG_REQ;
            ST_INTEG_REQ:  if (req_done_i) state_d = ST_INTEG_WAIT;
            ST_INTEG_WAIT: if (resp_confirm_i || timeout) state_d = ST_IDLE;
            default:       state_d = ST_IDLE;
        endcase
    end

    assign self_start = (state_q == ST_IDLE) && (state_d == ST_DB_REQ);
    assign nwr_start  = (state_q == ST_IDLE) && (state_d == ST_NWR);

    always_ff @(posedge log_clk) begin
        if (log_rst) begin
            state_q     <= ST_IDLE;
            timer_q     <= '0;
            parity_o    <= 1'b0;
            nwr_ready_o <= 1'b0;
            nwr_busy_o  <= 1'b0;
        end else begin
            state_q <= state_d;
            // Timer only runs while a response is outstanding
            timer_q <= waiting ? timer_q + 1'b1 : '0;
            if (nwr_ack_done_o) begin
                parity_o <= ~parity_o;
            end
            if (nwr_start) begin
                nwr_ready_o <= 1'b0;
            end else if (state_q == ST_DB_RESP && resp_ready_i) begin
                nwr_ready_o <= 1'b1;
            end else if (state_q == ST_DB_RESP && resp_busy_i) begin
                nwr_ready_o <= 1'b0;
            end
            if (self_start) begin
                nwr_busy_o <= 1'b0;
            end else if (state_q == ST_DB_RESP && resp_busy_i) begin
                nwr_busy_o <= 1'b1;
            end
        end
    end

    always_comb begin
        case (state_q)
            ST_DB_REQ, ST_INTEG_REQ: req_cmd_o = CMD_DOORBELL;
            ST_NWR:                  req_cmd_o = CMD_NWRITE;
            default:                 req_cmd_o = CMD_NONE;
        endcase
    end

    // Integrity code is 0x0201 on even parity and 0x0200 on odd
    assign db_info_o = ((state_q == ST_DB_REQ) || (state_q == ST_DB_RESP))
                     ? DB_INFO_SELF_CHECK
                     : DB_INFO_INTEG_BASE + {15'h0, ~parity_o};

    assign rapidio_ready_o = (state_q == ST_IDLE);
    assign nwr_ack_done_o  = (state_q == ST_INTEG_WAIT) && resp_confirm_i;
    assign error_o         = timeout;

    always_comb begin
        if (!timeout) begin
            error_type_o = ERR_NONE;
        end else if (state_q == ST_DB_RESP) begin
            error_type_o = ERR_DB_TIMEOUT;
        end else begin
            error_type_o = ERR_INTEG_TIMEOUT;
        end
    end

endmodule

//--- hw/srio_db_initiator.sv
`timescale 1ns/1ps

module srio_db_initiator (
    input  logic                   log_clk,
    input  logic                   log_rst,
    input  logic [15:0]            src_id_i,
    input  logic [15:0]            des_id_i,
    input  logic                   link_initialized_i,
    input  logic                   self_check_i,
    input  logic                   nwr_req_i,
    output logic                   rapidio_ready_o,
    output logic                   nwr_ready_o,
    output logic                   nwr_busy_o,
    output logic                   nwr_ack_done_o,
    output logic                   error_o,
    output db_ctrl_pkg::err_type_e error_type_o,
    // User payload stream
    input  logic                   user_tvalid_i,
    output logic                   user_tready_o,
    input  srio_pkg::beat_data_t   user_tdata_i,
    input  srio_pkg::beat_keep_t   user_tkeep_i,
    input  logic                   user_tlast_i,
    input  logic [7:0]             user_tsize_i,
    // Request stream to the link
    output logic                   ireq_tvalid_o,
    input  logic                   ireq_tready_i,
    output logic                   ireq_tlast_o,
    output srio_pkg::beat_data_t   ireq_tdata_o,
    output srio_pkg::beat_keep_t   ireq_tkeep_o,
    output srio_pkg::beat_user_t   ireq_tuser_o,
    // Response stream from the link
    input  logic                   iresp_tvalid_i,
    output logic                   iresp_tready_o,
    input  srio_pkg::beat_data_t   iresp_tdata_i,
    input  srio_pkg::beat_user_t   iresp_tuser_i
);
    import db_ctrl_pkg::*;

    req_cmd_e    req_cmd;
    logic [15:0] db_info;
    logic        parity;
    logic        req_done;
    logic        resp_ready;
    logic        resp_busy;
    logic        resp_confirm;

    srio_beat_if payload_if ();

    // Responses are always accepted
    assign iresp_tready_o = 1'b1;

    user_payload_fifo u_fifo (
        .log_clk       (log_clk),
        .log_rst       (log_rst),
        .user_tvalid_i (user_tvalid_i),
        .user_tready_o (user_tready_o),
        .user_tdata_i  (user_tdata_i),
        .user_tkeep_i  (user_tkeep_i),
        .user_tlast_i  (user_tlast_i),
        .user_tsize_i  (user_tsize_i),
        .head          (payload_if.source)
    );

    ireq_composer u_composer (
        .log_clk       (log_clk),
        .log_rst       (log_rst),
        .req_cmd_i     (req_cmd),
        .db_info_i     (db_info),
        .parity_i      (parity),
        .src_id_i      (src_id_i),
        .des_id_i      (des_id_i),
        .payload       (payload_if.sink),
        .ireq_tvalid_o (ireq_tvalid_o),
        .ireq_tready_i (ireq_tready_i),
        .ireq_tlast_o  (ireq_tlast_o),
        .ireq_tdata_o  (ireq_tdata_o),
        .ireq_tkeep_o  (ireq_tkeep_o),
        .ireq_tuser_o  (ireq_tuser_o),
        .req_done_o    (req_done)
    );

    // The info just sent is the one a confirm must echo
    iresp_decoder u_decoder (
        .log_clk        (log_clk),
        .log_rst        (log_rst),
        .des_id_i       (des_id_i),
        .expect_info_i  (db_info),
        .iresp_tvalid_i (iresp_tvalid_i),
        .iresp_tdata_i  (iresp_tdata_i),
        .iresp_tuser_i  (iresp_tuser_i),
        .resp_ready_o   (resp_ready),
        .resp_busy_o    (resp_busy),
        .resp_confirm_o (resp_confirm)
    );

    db_sequencer u_sequencer (
        .log_clk            (log_clk),
        .log_rst            (log_rst),
        .link_initialized_i (link_initialized_i),
        .self_check_i       (self_check_i),
        .nwr_req_i          (nwr_req_i),
        .req_done_i         (req_done),
        .resp_ready_i       (resp_ready),
        .resp_busy_i        (resp_busy),
        .resp_confirm_i     (resp_confirm),
        .req_cmd_o          (req_cmd),
        .db_info_o          (db_info),
        .parity_o           (parity),
        .rapidio_ready_o    (rapidio_ready_o),
        .nwr_ready_o        (nwr_ready_o),
        .nwr_busy_o         (nwr_busy_o),
        .nwr_ack_done_o     (nwr_ack_done_o),
        .error_o            (error_o),
        .error_type_o       (error_type_o)
    );

endmodule

//--- dv/srio_db_initiator_checker.sv
`timescale 1ns/1ps

module srio_db_initiator_checker (
    input  logic                   log_clk,
    input  logic                   log_rst,
    input  logic                   ireq_tvalid_o,
    input  logic                   ireq_tready_i,
    input  logic                   ireq_tlast_o,
    input  srio_pkg::beat_data_t   ireq_tdata_o,
    input  srio_pkg::beat_keep_t   ireq_tkeep_o,
    input  srio_pkg::beat_user_t   ireq_tuser_o,
    input  logic                   rapidio_ready_o,
    input  logic                   error_o,
    input  db_ctrl_pkg::err_type_e error_type_o
);
    import db_ctrl_pkg::*;

    int fail_count = 0;

    // A stalled request beat holds all of its fields
    stall_hold: assert property (@(posedge log_clk) disable iff (log_rst)
        ireq_tvalid_o && !ireq_tready_i |=>
            ireq_tvalid_o && $stable(ireq_tdata_o) && $stable(ireq_tlast_o)
            && $stable(ireq_tkeep_o) && $stable(ireq_tuser_o))
        else begin
            fail_count++;
            $error("Request beat changed while stalled");
        end

    // Requests are only presented away from idle
    valid_not_idle: assert property (@(posedge log_clk) disable iff (log_rst)
        ireq_tvalid_o |-> !rapidio_ready_o)
        else begin
            fail_count++;
            $error("rapidio_ready_o high while a request is presented");
        end

    // A timeout fires in a wait state and drops back to idle on the next cycle
    error_return: assert property (@(posedge log_clk) disable iff (log_rst)
        error_o |-> !rapidio_ready_o ##1 (rapidio_ready_o && !error_o))
        else begin
            fail_count++;
            $error("error_o is not a single pulse that returns to idle");
        end

    error_type_match: assert property (@(posedge log_clk) disable iff (log_rst)
        (error_type_o != ERR_NONE) == error_o)
        else begin
            fail_count++;
            $error("error_type_o disagrees with error_o");
        end

endmodule

bind srio_db_initiator srio_db_initiator_checker u_checker (
    .log_clk         (log_clk),
    .log_rst         (log_rst),
    .ireq_tvalid_o   (ireq_tvalid_o),
    .ireq_tready_i   (ireq_tready_i),
    .ireq_tlast_o    (ireq_tlast_o),
    .ireq_tdata_o    (ireq_tdata_o),
    .ireq_tkeep_o    (ireq_tkeep_o),
    .ireq_tuser_o    (ireq_tuser_o),
    .rapidio_ready_o (rapidio_ready_o),
    .error_o         (error_o),
    .error_type_o    (error_type_o)
);

//--- dv/tb_srio_db_initiator.sv
`timescale 1ns/1ps

module tb_srio_db_initiator;
    import srio_pkg::*;
    import db_ctrl_pkg::*;

    localparam int N_TESTS    = 5;
    localparam int WAIT_LIMIT = RESP_TIMEOUT_CYCLES + 200;
    localparam logic [15:0] SRC_ID = 16'h0011;
    localparam logic [15:0] DES_ID = 16'h00A5;

    logic log_clk = 1'b0;
    logic log_rst;
    logic [15:0] src_id_i, des_id_i;
    logic link_initialized_i, self_check_i, nwr_req_i;
    logic rapidio_ready_o, nwr_ready_o, nwr_busy_o, nwr_ack_done_o, error_o;
    err_type_e error_type_o;
    logic user_tvalid_i, user_tready_o, user_tlast_i;
    beat_data_t user_tdata_i;
    beat_keep_t user_tkeep_i;
    logic [7:0] user_tsize_i;
    logic ireq_tvalid_o, ireq_tready_i, ireq_tlast_o;
    beat_data_t ireq_tdata_o;
    beat_keep_t ireq_tkeep_o;
    beat_user_t ireq_tuser_o;
    logic iresp_tvalid_i, iresp_tready_o;
    beat_data_t iresp_tdata_i;
    beat_user_t iresp_tuser_i;

    int errors = 0;
    int checks = 0;
    beat_data_t payload_q[$];
    beat_keep_t keep_q[$];

    srio_db_initiator uut (.*);

    always #4 log_clk = ~log_clk;

    // Random back-pressure on the request stream
    always @(posedge log_clk) begin
        #1;
        ireq_tready_i = ($urandom % 4) != 0;
    end

    initial begin
        repeat (N_TESTS * WAIT_LIMIT) @(posedge log_clk);
        $display("Watchdog expired before the tests finished");
        $display("Test FAILED");
        $finish;
    end

    task check_value(input string name, input logic [63:0] expected, input logic [63:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("mismatch %s: expected %h actual %h", name, expected, actual);
        end
    endtask

    function logic pick_flag(input int which);
        case (which)
            0: pick_flag = nwr_ready_o;
            1: pick_flag = nwr_busy_o;
            2: pick_flag = nwr_ack_done_o;
            default: pick_flag = error_o;
        endcase
    endfunction

    // Returns at the negedge before the edge that accepts the beat
    task next_beat(output beat_data_t data, output beat_keep_t keep, output logic last,
                   output beat_user_t user);
        int n;
        n = 0;
        @(negedge log_clk);
        while (!(ireq_tvalid_o && ireq_tready_i) && n < WAIT_LIMIT) begin
            @(negedge log_clk);
            n++;
        end
        assert (ireq_tvalid_o && ireq_tready_i) else begin
            errors++;
            $display("No request beat was accepted in time");
        end
        data = ireq_tdata_o;
        keep = ireq_tkeep_o;
        last = ireq_tlast_o;
        user = ireq_tuser_o;
    endtask

    task await_flag(input string name, input int which);
        int n;
        n = 0;
        @(negedge log_clk);
        while (!pick_flag(which) && n < WAIT_LIMIT) begin
            @(negedge log_clk);
            n++;
        end
        assert (pick_flag(which)) else begin
            errors++;
            $display("Output %s never went high", name);
        end
    endtask

    task start_pulse(input bit nwr);
        @(posedge log_clk);
        #1;
        if (nwr) nwr_req_i = 1'b1;
        else self_check_i = 1'b1;
        @(posedge log_clk);
        #1;
        nwr_req_i    = 1'b0;
        self_check_i = 1'b0;
    endtask

    task send_response(input logic [15:0] info);
        @(posedge log_clk);
        #1;
        iresp_tvalid_i = 1'b1;
        iresp_tdata_i  = (64'hA << 52) | (64'(info) << 16);
        iresp_tuser_i  = {DES_ID, SRC_ID};
        @(negedge log_clk);
        check_value("iresp_tready_o", 64'h1, 64'(iresp_tready_o));
        @(posedge log_clk);
        #1;
        iresp_tvalid_i = 1'b0;
    endtask

    task push_payload(input int n, input logic [7:0] size);
        beat_data_t beat;
        beat_keep_t keep;
        payload_q.delete();
        keep_q.delete();
        for (int i = 0; i < n; i++) begin
            beat = {$urandom, $urandom};
            keep = 8'($urandom);
            @(posedge log_clk);
            #1;
            user_tvalid_i = 1'b1;
            user_tdata_i  = beat;
            user_tkeep_i  = keep;
            user_tlast_i  = (i == n - 1);
            user_tsize_i  = size;
            @(negedge log_clk);
            while (!user_tready_o) @(negedge log_clk);
            payload_q.push_back(beat);
            keep_q.push_back(keep);
        end
        @(posedge log_clk);
        #1;
        user_tvalid_i = 1'b0;
    endtask

    // Header, payload and integrity doorbell of one NWRITE
    task run_nwrite(input int n, input logic par);
        beat_data_t d, hdr;
        beat_keep_t k;
        logic l;
        beat_user_t u;
        push_payload(n, 8'(n * 8));
        start_pulse(1'b1);
        next_beat(d, k, l, u);
        hdr = (64'(par) << 56) | (64'h5 << 52) | (64'h4 << 48) | (64'h1 << 45)
            | (64'(n * 8) << 36) | (par ? 64'h1 << 20 : 64'h0);
        check_value("nwrite header", hdr, d);
        check_value("nwrite header last", 64'h0, 64'(l));
        for (int i = 0; i < n; i++) begin
            next_beat(d, k, l, u);
            check_value("nwrite payload", payload_q[i], d);
            check_value("nwrite keep", 64'(keep_q[i]), 64'(k));
            check_value("nwrite last", 64'(i == n - 1), 64'(l));
        end
        next_beat(d, k, l, u);
        check_value("integrity ftype", 64'hA, 64'(d[55:52]));
        check_value("integrity info", par ? 64'h0200 : 64'h0201, 64'(d[31:16]));
        check_value("integrity keep", 64'hFF, 64'(k));
        check_value("integrity last", 64'h1, 64'(l));
    endtask

    task timeout_check(input string name, input logic [1:0] exp_type);
        int n;
        n = 0;
        do begin
            @(negedge log_clk);
            n++;
        end while (!error_o && n < WAIT_LIMIT);
        check_value({name, " cycles"}, 64'(RESP_TIMEOUT_CYCLES), 64'(n));
        check_value({name, " type"}, 64'(exp_type), 64'(error_type_o));
        @(negedge log_clk);
        check_value({name, " back to idle"}, 64'h1, 64'(rapidio_ready_o));
    endtask

    initial begin
        beat_data_t d;
        beat_keep_t k;
        logic l;
        beat_user_t u;
        void'($urandom(91));
        log_rst = 1'b1;
        src_id_i = SRC_ID;
        des_id_i = DES_ID;
        link_initialized_i = 1'b1;
        self_check_i = 1'b0;
        nwr_req_i = 1'b0;
        user_tvalid_i = 1'b0;
        user_tdata_i = '0;
        user_tkeep_i = '1;
        user_tlast_i = 1'b0;
        user_tsize_i = '0;
        ireq_tready_i = 1'b0;
        iresp_tvalid_i = 1'b0;
        iresp_tdata_i = '0;
        iresp_tuser_i = '0;
        repeat (5) @(posedge log_clk);
        #1;
        log_rst = 1'b0;
        @(negedge log_clk);
        check_value("reset outputs", 64'h10,
                    64'({ireq_tvalid_o, rapidio_ready_o, nwr_ready_o, nwr_busy_o,
                         nwr_ack_done_o, error_o}));

        // Self-check answered ready
        start_pulse(1'b0);
        next_beat(d, k, l, u);
        check_value("self-check ftype", 64'hA, 64'(d[55:52]));
        check_value("self-check info", 64'(DB_INFO_SELF_CHECK), 64'(d[31:16]));
        check_value("self-check keep", 64'hFF, 64'(k));
        check_value("self-check last", 64'h1, 64'(l));
        check_value("self-check user", 64'({SRC_ID, DES_ID}), 64'(u));
        send_response(DB_INFO_READY);
        await_flag("nwr_ready_o", 0);

        // Busy target
        start_pulse(1'b0);
        next_beat(d, k, l, u);
        send_response(DB_INFO_BUSY);
        await_flag("nwr_busy_o", 1);
        check_value("busy keeps ready low", 64'h0, 64'(nwr_ready_o));

        // Two NWRITEs, parity flips on each confirm
        run_nwrite(5, 1'b0);
        send_response(16'h0201);
        await_flag("nwr_ack_done_o", 2);
        run_nwrite(3, 1'b1);
        send_response(16'h0200);
        await_flag("nwr_ack_done_o", 2);

        // Silent target
        start_pulse(1'b0);
        next_beat(d, k, l, u);
        timeout_check("doorbell timeout", 2'd1);
        run_nwrite(2, 1'b0);
        timeout_check("integrity timeout", 2'd2);

        $display("Checks run: %0d, errors: %0d, checker failures: %0d",
                 checks, errors, uut.u_checker.fail_count);
        if (errors == 0 && uut.u_checker.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- srio_db_initiator.f
hw/srio_pkg.sv
hw/db_ctrl_pkg.sv
hw/srio_beat_if.sv
hw/user_payload_fifo.sv
hw/ireq_composer.sv
hw/iresp_decoder.sv
hw/db_sequencer.sv
hw/srio_db_initiator.sv
dv/srio_db_initiator_checker.sv
dv/tb_srio_db_initiator.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_srio_db_initiator \
    -f srio_db_initiator.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_srio_db_initiator > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error"
fi
cat sim.log

if grep -q "^Test OK$" sim.log; then
    exit 0
fi
exit 1
